/* MulDivPkg.sv */
// ****************************************************************************
// Shared types and constants for the RV32 M-extension execute block
// Latencies count edges from the accepting edge to the first cycle of done
// Command encoding follows funct3, so a cast from funct3 is exact
// ****************************************************************************
`default_nettype none

package MulDivPkg;

    // ************************************************************************
    // Widths
    // ************************************************************************

    // One machine word
    localparam int DataWidth = 32;
    // x0..x31
    localparam int RegAddrWidth = 5;
    // Divider step counter, must reach DataWidth
    localparam int DivCountWidth = $clog2(DataWidth + 1);

    // ************************************************************************
    // Latencies
    // ************************************************************************

    // Operand stage, product stage, then done
    localparam int MulLatency = 2;
    // Load cycle, 32 steps, sign fix-up
    localparam int DivLatency = 33;

    // ************************************************************************
    // Encodings
    // ************************************************************************

    // OP major opcode, R-type
    localparam logic [6:0] OpcodeOp = 7'b0110011;
    // funct7 that selects the M extension
    localparam logic [6:0] Funct7MulDiv = 7'b0000001;

    // funct3 order of the M extension
    typedef enum logic [2:0] {
        Mul,
        Mulh,
        Mulhsu,
        Mulhu,
        Div,
        Divu,
        Rem,
        Remu
    } MulDivCommand;

    // Decoded operation, 9 bits
    typedef struct packed {
        MulDivCommand command;
        logic [RegAddrWidth-1:0] rd;
        logic legal;
    } MulDivOp;

endpackage

`default_nettype wire

/* MulDivDecoder.sv */
// ****************************************************************************
// Pure combinational decode of one instruction word
// Only OP opcode with funct7 0000001 is legal
// Illegal words still carry a command, but legal stays low
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivDecoder (
    input  wire logic [MulDivPkg::DataWidth-1:0] instr,
    output MulDivPkg::MulDivOp                   op
);
    import MulDivPkg::*;

    // Instruction fields
    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic [RegAddrWidth-1:0] rd;
    logic isMulDiv;

    // R-type field positions
    always_comb begin
        opcode = instr[6:0];
        rd = instr[11:7];
        funct3 = instr[14:12];
        funct7 = instr[31:25];
    end

    // rs1 and rs2 are read by the register file, not here
    always_comb begin
        isMulDiv = (opcode == OpcodeOp) && (funct7 == Funct7MulDiv);
    end

    always_comb begin
        op.rd = rd;
        op.legal = isMulDiv;

        // funct3 maps straight onto the enum
        if (isMulDiv) begin
            op.command = MulDivCommand'(funct3);
        end
        else begin
            // Harmless default, never run
            op.command = Mul;
        end
    end

endmodule

`default_nettype wire

/* MulUnit.sv */
// ****************************************************************************
// Two-stage 33x33 signed multiplier, one operation at a time
// Operands must stay stable while enable is high
// done rises MulLatency edges after the accepting edge, stall adds cycles
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulUnit (
    input  wire logic                            clk,
    input  wire logic                            rstN,
    input  wire logic                            enable,
    input  wire logic                            stall,
    input  wire logic                            flush,
    input  wire logic                            high,
    input  wire logic                            src1Signed,
    input  wire logic                            src2Signed,
    input  wire logic [MulDivPkg::DataWidth-1:0] src1,
    input  wire logic [MulDivPkg::DataWidth-1:0] src2,
    output logic                                 done,
    output logic      [MulDivPkg::DataWidth-1:0] result
);
    import MulDivPkg::*;

    // Stage one, operands widened by one bit
    logic signed [DataWidth:0] op1Reg;
    logic signed [DataWidth:0] op2Reg;
    // Stage two, full product
    logic signed [2*DataWidth+1:0] productReg;
    // Stage occupancy, bit 0 first
    logic [MulLatency-1:0] validPipe;

    // ************************************************************************
    // Datapath
    // ************************************************************************

    // Unsigned sources get a zero top bit, so one signed multiply covers all
    always_ff @(posedge clk) begin
        if (enable && !stall) begin
            op1Reg <= {src1Signed & src1[DataWidth-1], src1};
            op2Reg <= {src2Signed & src2[DataWidth-1], src2};
            productReg <= op1Reg * op2Reg;
        end
    end

    // Word select from the product register
    always_comb begin
        if (high) begin
            result = productReg[2*DataWidth-1:DataWidth];
        end
        else begin
            result = productReg[DataWidth-1:0];
        end
    end

    // ************************************************************************
    // Control
    // ************************************************************************

    // Falling enable or flush empties the pipe
    always_ff @(posedge clk) begin
        if (!rstN || flush || !enable) begin
            validPipe <= '0;
            done <= 1'b0;
        end
        else if (!stall) begin
            // Ones fill in behind the operation
            validPipe <= {validPipe[MulLatency-2:0], 1'b1};
            // Product has settled in stage two
            done <= validPipe[MulLatency-1];
        end
    end

endmodule

`default_nettype wire

/* DivUnit.sv */
// ****************************************************************************
// Radix-2 restoring divider, fixed DivLatency, no early out
// Dividend and divisor must stay stable until done
// Divide by zero and signed overflow follow the RISC-V results
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module DivUnit (
    input  wire logic                            clk,
    input  wire logic                            rstN,
    input  wire logic                            enable,
    input  wire logic                            stall,
    input  wire logic                            flush,
    input  wire logic                            isSigned,
    input  wire logic [MulDivPkg::DataWidth-1:0] dividend,
    input  wire logic [MulDivPkg::DataWidth-1:0] divisor,
    output logic                                 done,
    output logic      [MulDivPkg::DataWidth-1:0] quotient,
    output logic      [MulDivPkg::DataWidth-1:0] remainder
);
    import MulDivPkg::*;

    // Most negative word
    localparam logic [DataWidth-1:0] MinInt = {1'b1, {(DataWidth-1){1'b0}}};

    logic busy;
    logic [DivCountWidth-1:0] count;
    logic lastStep;
    logic start;
    // Quotient shifts in from the bottom, dividend shifts out the top
    logic [DataWidth-1:0] quoReg;
    logic [DataWidth-1:0] remReg;
    logic [DataWidth-1:0] divisorMag;
    logic quoNeg;
    logic remNeg;
    logic divByZero;
    logic overflow;
    // Magnitudes of the raw inputs
    logic [DataWidth-1:0] dividendAbs;
    logic [DataWidth-1:0] divisorAbs;
    // One trial subtract
    logic [DataWidth:0] shifted;
    logic [DataWidth+1:0] trial;

    always_comb begin
        dividendAbs = (isSigned && dividend[DataWidth-1]) ? -dividend : dividend;
        divisorAbs = (isSigned && divisor[DataWidth-1]) ? -divisor : divisor;
        start = !busy && !done;
        lastStep = (count == DivCountWidth'(DataWidth));
        shifted = {remReg, quoReg[DataWidth-1]};
        // Top bit set means borrow, so restore
        trial = {1'b0, shifted} - {2'b00, divisorMag};
    end

    // ************************************************************************
    // Control
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (!rstN || flush || !enable) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end
        else if (!stall) begin
            if (start) begin
                busy <= 1'b1;
                count <= '0;
            end
            else if (busy && !lastStep) begin
                count <= count + 1'b1;
            end
            else if (busy) begin
                // Held until enable falls
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ************************************************************************
    // Datapath
    // ************************************************************************

    always_ff @(posedge clk) begin
        if (enable && !stall) begin
            if (start) begin
                quoReg <= dividendAbs;
                remReg <= '0;
                divisorMag <= divisorAbs;
                // Result signs, applied at the end
                quoNeg <= isSigned && (dividend[DataWidth-1] ^ divisor[DataWidth-1]);
                remNeg <= isSigned && dividend[DataWidth-1];
                divByZero <= (divisor == '0);
                overflow <= isSigned && (dividend == MinInt) && (divisor == '1);
            end
            else if (busy && !lastStep) begin
                if (!trial[DataWidth+1]) begin
                    remReg <= trial[DataWidth-1:0];
                    quoReg <= {quoReg[DataWidth-2:0], 1'b1};
                end
                else begin
                    remReg <= shifted[DataWidth-1:0];
                    quoReg <= {quoReg[DataWidth-2:0], 1'b0};
                end
            end
            else if (busy) begin
                // Inputs still stable here, so the raw dividend is usable
                if (divByZero) begin
                    quoReg <= '1;
                    remReg <= dividend;
                end
                else if (overflow) begin
                    quoReg <= dividend;
                    remReg <= '0;
                end
                else begin
                    quoReg <= quoNeg ? -quoReg : quoReg;
                    remReg <= remNeg ? -remReg : remReg;
                end
            end
        end
    end

    // Valid only while done is high
    assign quotient = quoReg;
    assign remainder = remReg;

endmodule

`default_nettype wire

/* MulDivUnit.sv */
// ****************************************************************************
// Execute stage, steers one command to the multiplier or the divider
// Only the selected unit sees enable, the other stays idle
// command and sources must stay stable while enable is high
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivUnit (
    input  wire logic                            clk,
    input  wire logic                            rstN,
    input  wire logic                            enable,
    input  wire logic                            stall,
    input  wire logic                            flush,
    input  wire MulDivPkg::MulDivCommand         command,
    input  wire logic [MulDivPkg::DataWidth-1:0] src1,
    input  wire logic [MulDivPkg::DataWidth-1:0] src2,
    output logic                                 done,
    output logic      [MulDivPkg::DataWidth-1:0] result
);
    import MulDivPkg::*;

    // Multiplier side
    logic mulEnable;
    logic mulDone;
    logic [DataWidth-1:0] mulResult;
    logic mulHigh;
    logic mulSrc1Signed;
    logic mulSrc2Signed;

    // Divider side
    logic divEnable;
    logic divDone;
    logic [DataWidth-1:0] quotient;
    logic [DataWidth-1:0] remainder;
    logic divSigned;
    logic isMul;

    // Command class and sign controls
    always_comb begin
        isMul = (command == Mul) || (command == Mulh) ||
                (command == Mulhsu) || (command == Mulhu);
        mulHigh = (command == Mulh) || (command == Mulhsu) || (command == Mulhu);
        mulSrc1Signed = (command == Mulh) || (command == Mulhsu);
        mulSrc2Signed = (command == Mulh);
        divSigned = (command == Div) || (command == Rem);
        mulEnable = enable && isMul;
        divEnable = enable && !isMul;
    end

    MulUnit mulUnit (
        .clk, .rstN, .stall, .flush,
        .enable(mulEnable), .high(mulHigh),
        .src1Signed(mulSrc1Signed), .src2Signed(mulSrc2Signed),
        .src1, .src2,
        .done(mulDone), .result(mulResult)
    );

    DivUnit divUnit (
        .clk, .rstN, .stall, .flush,
        .enable(divEnable), .isSigned(divSigned),
        .dividend(src1), .divisor(src2),
        .done(divDone), .quotient, .remainder
    );

    // Output select by command
    always_comb begin
        if (isMul) begin
            done = mulDone;
            result = mulResult;
        end
        else if ((command == Div) || (command == Divu)) begin
            done = divDone;
            result = quotient;
        end
        else begin
            done = divDone;
            result = remainder;
        end
    end

endmodule

`default_nettype wire

/* MulDivWriteback.sv */
// ****************************************************************************
// Turns the done level into one write-back pulse per operation
// The register file must accept every pulse, there is no back-pressure
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivWriteback (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic                               flush,
    input  wire logic                               done,
    input  wire logic [MulDivPkg::DataWidth-1:0]    result,
    input  wire logic [MulDivPkg::RegAddrWidth-1:0] rd,
    output logic                                    writeValid,
    output logic      [MulDivPkg::RegAddrWidth-1:0] writeRd,
    output logic      [MulDivPkg::DataWidth-1:0]    writeData
);
    // Set once the current operation has written
    logic issued;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issued <= 1'b0;
            writeValid <= 1'b0;
            writeRd <= '0;
            writeData <= '0;
        end
        else if (flush || !done) begin
            // Abort or end of operation, rearm
            issued <= 1'b0;
            writeValid <= 1'b0;
        end
        else if (!issued) begin
            // First cycle of done
            issued <= 1'b1;
            writeValid <= 1'b1;
            writeRd <= rd;
            writeData <= result;
        end
        else begin
            // done held high, already written
            writeValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* MulDivCore.sv */
// ****************************************************************************
// M-extension block, decode, execute and write-back
// enable is a level held until done, then low for at least one cycle
// illegal is combinational and only meaningful while enable is high
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivCore (
    input  wire logic                               clk,
    input  wire logic                               rstN,
    input  wire logic [MulDivPkg::DataWidth-1:0]    instr,
    input  wire logic [MulDivPkg::DataWidth-1:0]    src1,
    input  wire logic [MulDivPkg::DataWidth-1:0]    src2,
    input  wire logic                               enable,
    input  wire logic                               stall,
    input  wire logic                               flush,
    output logic                                    illegal,
    output logic                                    done,
    output logic                                    writeValid,
    output logic      [MulDivPkg::RegAddrWidth-1:0] writeRd,
    output logic      [MulDivPkg::DataWidth-1:0]    writeData
);
    import MulDivPkg::*;

    MulDivOp op;
    logic legalEnable;
    logic [DataWidth-1:0] result;

    // Illegal words never reach the execute stage
    assign legalEnable = enable & op.legal;
    assign illegal = enable & ~op.legal;

    MulDivDecoder decoder (
        .instr,
        .op
    );

    MulDivUnit execute (
        .clk, .rstN, .stall, .flush,
        .enable(legalEnable),
        .command(op.command),
        .src1, .src2,
        .done, .result
    );

    // rd comes from the still-stable instruction word
    MulDivWriteback writeback (
        .clk, .rstN, .flush,
        .done, .result,
        .rd(op.rd),
        .writeValid, .writeRd, .writeData
    );

endmodule

`default_nettype wire

/* MulDivCore_assert.sv */
// ****************************************************************************
// Protocol checks on the M-extension block, bound to every instance
// Only reports through failing assertions
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivCoreAssert (
    input wire logic clk,
    input wire logic rstN,
    input wire logic flush,
    input wire logic illegal,
    input wire logic done,
    input wire logic writeValid
);

    // One pulse per operation
    assert property (@(posedge clk) disable iff (!rstN) writeValid |=> !writeValid)
        else $error("writeValid high on two consecutive cycles");

    // Reset holds the write port quiet
    assert property (@(posedge clk) !rstN |=> !writeValid)
        else $error("writeValid high during reset");

    // Flush suppresses the pulse in the following cycle
    assert property (@(posedge clk) disable iff (!rstN) flush |=> !writeValid)
        else $error("writeValid high in the cycle after flush");

    // Illegal words never reach the execute stage
    assert property (@(posedge clk) disable iff (!rstN) illegal |-> !$rose(done))
        else $error("done rose while illegal was high");

endmodule

bind MulDivCore MulDivCoreAssert coreAssert (
    .clk,
    .rstN,
    .flush,
    .illegal,
    .done,
    .writeValid
);

`default_nettype wire

/* MulDivModel.svh */
// ****************************************************************************
// Reference results for the RV32 M extension, taken from the ISA rules
// Included inside the testbench module, after the package import
// Division by zero and signed overflow follow the RISC-V results
// ****************************************************************************
`ifndef MULDIVMODEL_SVH
`define MULDIVMODEL_SVH

// Full product, each source widened as signed or unsigned
function automatic logic [63:0] wideProduct(
    input logic [31:0] a,
    input logic [31:0] b,
    input bit          aSigned,
    input bit          bSigned
);
    longint wideA;
    longint wideB;
    if (aSigned) begin
        wideA = longint'($signed(a));
    end
    else begin
        wideA = longint'(a);
    end
    if (bSigned) begin
        wideB = longint'($signed(b));
    end
    else begin
        wideB = longint'(b);
    end
    // Wraps modulo 2^64, the bits stay exact
    return wideA * wideB;
endfunction

// Expected write-back word for one operation
function automatic logic [31:0] expectedResult(
    input MulDivCommand cmd,
    input logic [31:0]  a,
    input logic [31:0]  b
);
    logic [63:0] product;
    int signedA;
    int signedB;
    // Low word is the same for any sign choice
    product = wideProduct(a, b, cmd != Mulhu, (cmd == Mul) || (cmd == Mulh));
    signedA = a;
    signedB = b;
    case (cmd)
        Mul: return product[31:0];
        Mulh, Mulhsu, Mulhu: return product[63:32];
        Div: begin
            if (b == 32'h0) begin
                return 32'hffff_ffff;
            end
            if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
                return a;
            end
            // Truncates toward zero
            return signedA / signedB;
        end
        Divu: begin
            if (b == 32'h0) begin
                return 32'hffff_ffff;
            end
            return a / b;
        end
        Rem: begin
            if (b == 32'h0) begin
                return a;
            end
            if ((a == 32'h8000_0000) && (b == 32'hffff_ffff)) begin
                return 32'h0;
            end
            // Sign of the dividend
            return signedA % signedB;
        end
        default: begin
            if (b == 32'h0) begin
                return a;
            end
            return a % b;
        end
    endcase
endfunction

`endif

/* MulDivTb.sv */
// ****************************************************************************
// Random testbench for the M-extension block, fixed seed 92224
// Inputs change on the falling edge, outputs are sampled there too
// Every wait on the DUT is bounded, a timeout ends the run
// ****************************************************************************
`default_nettype none
`timescale 1ns/1ps

module MulDivTb;
    import MulDivPkg::*;

    // Edges from the accepting edge up to the one that raises done
    localparam int MulDoneEdges = 3;
    localparam int DivDoneEdges = 34;
    // R-type encodings of the M extension
    localparam logic [6:0] OpOpcode = 7'b0110011;
    localparam logic [6:0] MulDivFunct7 = 7'b0000001;
    // Slack on top of the nominal latency
    localparam int Margin = 8;
    localparam int MaxStall = 12;
    localparam int OpsPerGroup = 48;

    logic clk;
    logic rstN;
    logic [DataWidth-1:0] instr;
    logic [DataWidth-1:0] src1;
    logic [DataWidth-1:0] src2;
    logic enable;
    logic stall;
    logic flush;
    logic illegal;
    logic done;
    logic writeValid;
    logic [RegAddrWidth-1:0] writeRd;
    logic [DataWidth-1:0] writeData;

    int errorCount;
    int checkCount;
    int opCount;
    bit timedOut;

    `include "MulDivModel.svh"

    MulDivCore MulDivCore_inst (
        .clk, .rstN, .instr, .src1, .src2, .enable, .stall, .flush,
        .illegal, .done, .writeValid, .writeRd, .writeData
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ************************************************************************
    // Helpers
    // ************************************************************************

    task automatic flagError(input string msg);
        errorCount++;
        $display("[FAIL] t=%0t %s", $time, msg);
    endtask

    function automatic bit isMulCommand(input MulDivCommand cmd);
        return (cmd == Mul) || (cmd == Mulh) || (cmd == Mulhsu) || (cmd == Mulhu);
    endfunction

    // About one in eight is a corner value
    function automatic logic [DataWidth-1:0] randOperand();
        int pick;
        pick = $urandom % 24;
        if (pick == 0) begin
            return 32'h0;
        end
        else if (pick == 1) begin
            return 32'hffff_ffff;
        end
        else if (pick == 2) begin
            return 32'h8000_0000;
        end
        return $urandom;
    endfunction

    // rs1 and rs2 are don't-care here
    function automatic logic [DataWidth-1:0] buildInstr(
        input logic [6:0] funct7,
        input logic [2:0] funct3,
        input logic [4:0] rd,
        input logic [6:0] opcode
    );
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = $urandom;
        rs2 = $urandom;
        return {funct7, rs2, rs1, funct3, rd, opcode};
    endfunction

    task automatic reportGroup(input string name, input int opsBefore, input int errBefore);
        $display("%-8s %0d operations, %0d errors", name, opCount - opsBefore,
                 errorCount - errBefore);
    endtask

    // ************************************************************************
    // Operations
    // ************************************************************************

    // One legal operation, checks data, rd and latency
    task automatic executeOp(
        input MulDivCommand        cmd,
        input logic [DataWidth-1:0] a,
        input logic [DataWidth-1:0] b,
        input bit                  useStall
    );
        logic [DataWidth-1:0] expected;
        logic [RegAddrWidth-1:0] rd;
        int needed;
        int advances;
        int stalls;
        int waited;
        bit seen;
        rd = $urandom;
        expected = expectedResult(cmd, a, b);
        needed = isMulCommand(cmd) ? MulDoneEdges : DivDoneEdges;
        instr = buildInstr(MulDivFunct7, cmd, rd, OpOpcode);
        src1 = a;
        src2 = b;
        enable = 1'b1;
        stall = useStall && ($urandom % 4 == 0);
        advances = 0;
        stalls = 0;
        waited = 0;
        seen = 1'b0;
        while (!seen && (waited < DivLatency + MaxStall + Margin)) begin
            @(negedge clk);
            waited++;
            // Stalled edges before done stretch the latency
            if (advances < needed) begin
                if (stall) begin
                    stalls++;
                end
                else begin
                    advances++;
                end
            end
            seen = writeValid;
            stall = useStall && (advances < needed) && (stalls < MaxStall) &&
                    ($urandom % 4 == 0);
        end
        stall = 1'b0;
        opCount++;
        if (!seen) begin
            $display("Timeout: no write-back for %s after %0d cycles", cmd.name(), waited);
            timedOut = 1'b1;
            enable = 1'b0;
            return;
        end
        checkCount += 4;
        if (writeData !== expected) begin
            flagError($sformatf("%s %h, %h gave %h, expected %h", cmd.name(), a, b,
                                writeData, expected));
        end
        if (writeRd !== rd) begin
            flagError($sformatf("%s writeRd %0d, expected %0d", cmd.name(), writeRd, rd));
        end
        // writeValid lands one edge after done
        if (waited != needed + stalls + 1) begin
            flagError($sformatf("%s latency %0d edges with %0d stalls, expected %0d",
                                cmd.name(), waited - 1, stalls, needed + stalls));
        end
        if (illegal !== 1'b0) begin
            flagError($sformatf("illegal high for a legal %s", cmd.name()));
        end
        enable = 1'b0;
        @(negedge clk);
        checkCount++;
        if (writeValid !== 1'b0) begin
            flagError("writeValid held for a second cycle");
        end
    endtask

    // Flush at or before the write-back edge, no write-back may follow
    task automatic flushMidOp(input MulDivCommand cmd);
        logic [RegAddrWidth-1:0] rd;
        int needed;
        int flushAt;
        int i;
        bit early;
        bit late;
        rd = $urandom;
        needed = isMulCommand(cmd) ? MulDoneEdges : DivDoneEdges;
        flushAt = $urandom % (needed + 1);
        instr = buildInstr(MulDivFunct7, cmd, rd, OpOpcode);
        src1 = randOperand();
        src2 = randOperand();
        enable = 1'b1;
        early = 1'b0;
        late = 1'b0;
        for (i = 0; i < flushAt; i++) begin
            @(negedge clk);
            early = early | writeValid;
        end
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        enable = 1'b0;
        late = writeValid | done;
        for (i = 0; i < needed + Margin; i++) begin
            @(negedge clk);
            late = late | writeValid;
        end
        opCount++;
        checkCount += 2;
        if (early) begin
            flagError($sformatf("%s wrote back before the flush point", cmd.name()));
        end
        if (late) begin
            flagError($sformatf("%s wrote back after flush at edge %0d", cmd.name(), flushAt));
        end
    endtask

    // Wrong opcode or funct7, must never run
    task automatic checkIllegalWord();
        logic [6:0] opcode;
        logic [6:0] funct7;
        logic [2:0] funct3;
        logic [4:0] rd;
        int i;
        bit bad;
        opcode = $urandom;
        funct7 = $urandom;
        funct3 = $urandom;
        rd = $urandom;
        if ($urandom % 2) begin
            opcode = OpOpcode;
            if (funct7 == MulDivFunct7) begin
                funct7 = 7'b0100000;
            end
        end
        else begin
            funct7 = MulDivFunct7;
            if (opcode == OpOpcode) begin
                opcode = 7'b0010011;
            end
        end
        instr = buildInstr(funct7, funct3, rd, opcode);
        src1 = randOperand();
        src2 = randOperand();
        enable = 1'b1;
        bad = 1'b0;
        for (i = 0; i < DivLatency + Margin; i++) begin
            @(negedge clk);
            if ((illegal !== 1'b1) || (done !== 1'b0) || (writeValid !== 1'b0)) begin
                bad = 1'b1;
            end
        end
        enable = 1'b0;
        @(negedge clk);
        opCount++;
        checkCount += 2;
        if (bad) begin
            flagError($sformatf("word %h not flagged or ran anyway", instr));
        end
        if (illegal !== 1'b0) begin
            flagError("illegal still high with enable low");
        end
    endtask

    // ************************************************************************
    // Sequence
    // ************************************************************************

    initial begin
        int i;
        int opsBefore;
        int errBefore;
        MulDivCommand cmd;
        clk = 1'b0;
        rstN = 1'b0;
        instr = '0;
        src1 = '0;
        src2 = '0;
        enable = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        errorCount = 0;
        checkCount = 0;
        opCount = 0;
        timedOut = 1'b0;
        void'($urandom(92224));

        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        // Multiply commands, no stall
        opsBefore = opCount;
        errBefore = errorCount;
        for (i = 0; (i < OpsPerGroup) && !timedOut; i++) begin
            cmd = MulDivCommand'(i % 4);
            executeOp(cmd, randOperand(), randOperand(), 1'b0);
        end
        reportGroup("mul", opsBefore, errBefore);

        // Divide and remainder, random then the special cases
        opsBefore = opCount;
        errBefore = errorCount;
        for (i = 0; (i < OpsPerGroup) && !timedOut; i++) begin
            cmd = MulDivCommand'(4 + i % 4);
            executeOp(cmd, randOperand(), randOperand(), 1'b0);
        end
        for (i = 4; (i < 8) && !timedOut; i++) begin
            cmd = MulDivCommand'(i);
            executeOp(cmd, $urandom, 32'h0, 1'b0);
            executeOp(cmd, 32'h0, 32'h0, 1'b0);
            executeOp(cmd, 32'h8000_0000, 32'hffff_ffff, 1'b0);
        end
        reportGroup("div", opsBefore, errBefore);

        // Random stall on any command
        opsBefore = opCount;
        errBefore = errorCount;
        for (i = 0; (i < OpsPerGroup) && !timedOut; i++) begin
            cmd = MulDivCommand'($urandom % 8);
            executeOp(cmd, randOperand(), randOperand(), 1'b1);
        end
        reportGroup("stall", opsBefore, errBefore);

        // Flush, then a normal operation
        opsBefore = opCount;
        errBefore = errorCount;
        for (i = 0; (i < OpsPerGroup / 2) && !timedOut; i++) begin
            flushMidOp(MulDivCommand'($urandom % 8));
            cmd = MulDivCommand'($urandom % 8);
            executeOp(cmd, randOperand(), randOperand(), 1'b0);
        end
        reportGroup("flush", opsBefore, errBefore);

        // Non-M-extension words
        opsBefore = opCount;
        errBefore = errorCount;
        for (i = 0; (i < OpsPerGroup / 4) && !timedOut; i++) begin
            checkIllegalWord();
        end
        reportGroup("illegal", opsBefore, errBefore);

        $display("Summary: %0d operations, %0d checks, %0d errors%s", opCount, checkCount,
                 errorCount, timedOut ? ", run stopped by timeout" : "");
        if ((errorCount == 0) && !timedOut) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
MulDivPkg.sv
MulDivDecoder.sv
MulUnit.sv
DivUnit.sv
MulDivUnit.sv
MulDivWriteback.sv
MulDivCore.sv
MulDivCore_assert.sv
MulDivTb.sv
